//--- design/tcu_pkg.sv
package tcu_pkg;

	// Bus widths
	localparam int TCU_ADDR_W = 32;
	localparam int TCU_DATA_W = 32;
	localparam int TCU_STRB_W = TCU_DATA_W / 8;
	localparam int TCU_LEN_W = 8;

	// Region table size
	localparam int TCU_NUM_TC = 4;
	localparam int TCU_IDX_W = $clog2(TCU_NUM_TC);

	// Address step of one full-width beat
	localparam int TCU_BEAT_BYTES = TCU_DATA_W / 8;

	typedef logic [TCU_ADDR_W-1:0] addr_t;
	typedef logic [TCU_DATA_W-1:0] data_t;
	typedef logic [TCU_STRB_W-1:0] strb_t;
	typedef logic [TCU_LEN_W-1:0] len_t;
	typedef logic [1:0] resp_t;

	// ********************************************************
	// Register map
	// Region i occupies 16 bytes starting at REG_REGION_BASE + 16*i
	localparam logic [7:0] REG_ENABLE = 8'h00;
	localparam logic [7:0] REG_REGION_BASE = 8'h10;
	localparam logic [3:0] REG_BASE_OFS = 4'h0;
	localparam logic [3:0] REG_LIMIT_OFS = 4'h4;
	localparam logic [3:0] REG_TARGET_OFS = 4'h8;

	// Address arbiter states
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_RD_ISSUE,
		ARB_WR_ISSUE,
		ARB_WR_DATA
	} arb_state_t;

endpackage

//--- design/tcu_if.sv
`timescale 1ns/10ps

// Region table as seen by the lookup logic
interface tcu_region_if;
	import tcu_pkg::*;

	logic [TCU_NUM_TC-1:0] enable;
	addr_t base [TCU_NUM_TC];
	addr_t limit [TCU_NUM_TC];
	addr_t target [TCU_NUM_TC];

	modport regs (output enable, output base, output limit, output target);
	modport match (input enable, input base, input limit, input target);
endinterface

// Shared translator port between arbiter and region match
interface tcu_lookup_if;
	import tcu_pkg::*;

	addr_t addr;
	logic hit;
	addr_t xaddr;
	addr_t limit;

	modport client (output addr, input hit, input xaddr);
	modport server (input addr, output hit, output xaddr, output limit);
endinterface

//--- design/tcu_apb_regs.sv
`timescale 1ns/10ps

module tcu_apb_regs
(
	input  logic clk,
	input  logic rstnn,
	input  tcu_pkg::addr_t paddr,
	input  logic pwrite,
	input  logic psel,
	input  logic penable,
	input  tcu_pkg::data_t pwdata,
	output tcu_pkg::data_t prdata,
	output logic pready,
	output logic pslverr,
	tcu_region_if.regs region
);
	import tcu_pkg::*;

	logic [7:0] region_ofs;
	logic [TCU_IDX_W-1:0] idx;
	logic [3:0] field;
	logic upper_zero;
	logic sel_enable;
	logic in_table;
	logic field_ok;
	logic mapped;
	logic wr_en;

	// ********************************************************
	// Address decode
	assign upper_zero = (paddr[TCU_ADDR_W-1:8] == '0);
	assign sel_enable = upper_zero && (paddr[7:0] == REG_ENABLE);
	assign region_ofs = paddr[7:0] - REG_REGION_BASE;
	assign idx = region_ofs[TCU_IDX_W+3:4];
	assign field = region_ofs[3:0];
	assign in_table = upper_zero && (paddr[7:0] >= REG_REGION_BASE) &&
		(region_ofs[7:4] < 4'(TCU_NUM_TC));
	assign field_ok = (field == REG_BASE_OFS) || (field == REG_LIMIT_OFS) ||
		(field == REG_TARGET_OFS);
	assign mapped = sel_enable || (in_table && field_ok);

	// Every access finishes in its enable cycle
	assign pready = psel && penable;
	assign pslverr = pready && !mapped;
	assign wr_en = pready && pwrite && mapped;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			region.enable <= '0;
		else if (wr_en && sel_enable)
			region.enable <= pwdata[TCU_NUM_TC-1:0];
	end

	// Region entry writes
	always_ff @(posedge clk)
	begin
		if (wr_en && in_table)
		begin
			case (field)
				REG_BASE_OFS: region.base[idx] <= pwdata;
				REG_LIMIT_OFS: region.limit[idx] <= pwdata;
				REG_TARGET_OFS: region.target[idx] <= pwdata;
				default: ;
			endcase
		end
	end

	// Read mux returns zero for unmapped offsets
	always_comb
	begin
		prdata = '0;
		if (sel_enable)
			prdata = data_t'(region.enable);
		else if (in_table)
		begin
			case (field)
				REG_BASE_OFS: prdata = data_t'(region.base[idx]);
				REG_LIMIT_OFS: prdata = data_t'(region.limit[idx]);
				REG_TARGET_OFS: prdata = data_t'(region.target[idx]);
				default: prdata = '0;
			endcase
		end
	end

	a_slverr_zero_data: assert property (@(posedge clk) disable iff (!rstnn)
		pslverr |-> (prdata == '0));

endmodule

//--- design/tcu_region_match.sv
`timescale 1ns/10ps

module tcu_region_match
(
	tcu_region_if.match region,
	tcu_lookup_if.server lookup
);
	import tcu_pkg::*;

	logic [TCU_NUM_TC-1:0] win;

	// ********************************************************
	// Window compare against an exclusive limit
	always_comb
	begin
		for (int i = 0; i < TCU_NUM_TC; i++)
		begin
			win[i] = region.enable[i] &&
				(lookup.addr >= region.base[i]) &&
				(lookup.addr < region.limit[i]);
		end
	end

	// Priority pick
	// Scan downward so the lowest matching index is applied last
	always_comb
	begin
		lookup.hit = 1'b0;
		lookup.xaddr = lookup.addr;
		lookup.limit = '0;
		for (int i = TCU_NUM_TC - 1; i >= 0; i--)
		begin
			if (win[i])
			begin
				lookup.hit = 1'b1;
				lookup.xaddr = region.target[i] + (lookup.addr - region.base[i]);
				lookup.limit = region.limit[i];
			end
		end
	end

endmodule

//--- design/tcu_addr_arbiter.sv
`timescale 1ns/10ps

module tcu_addr_arbiter
(
	input  logic clk,
	input  logic rstnn,
	input  tcu_pkg::addr_t s_araddr,
	input  tcu_pkg::len_t s_arlen,
	input  logic s_arvalid,
	output logic s_arready,
	input  tcu_pkg::addr_t s_awaddr,
	input  tcu_pkg::len_t s_awlen,
	input  logic s_awvalid,
	output logic s_awready,
	input  logic s_wvalid,
	output logic s_wready,
	output tcu_pkg::addr_t m_araddr,
	output tcu_pkg::len_t m_arlen,
	output logic m_arvalid,
	input  logic m_arready,
	output tcu_pkg::addr_t m_awaddr,
	output tcu_pkg::len_t m_awlen,
	output logic m_awvalid,
	input  logic m_awready,
	output logic m_wvalid,
	input  logic m_wready,
	input  logic m_wlast_seen,
	output logic wr_start,
	output logic wr_beat,
	output logic wr_hit,
	tcu_lookup_if.client lookup
);
	import tcu_pkg::*;

	arb_state_t state;
	arb_state_t state_nx;
	addr_t addr_q;
	len_t len_q;
	logic take_rd;
	logic take_wr;
	logic wr_done;

	// Reads win when both address channels are pending
	assign take_rd = (state == ARB_IDLE) && s_arvalid;
	assign take_wr = (state == ARB_IDLE) && !s_arvalid && s_awvalid;

	// One address register feeds the shared translator
	always_ff @(posedge clk)
	begin
		if (take_rd)
		begin
			addr_q <= s_araddr;
			len_q <= s_arlen;
		end
		else if (take_wr)
		begin
			addr_q <= s_awaddr;
			len_q <= s_awlen;
		end
	end

	assign lookup.addr = addr_q;

	// ********************************************************
	// Channel gating
	assign m_araddr = lookup.xaddr;
	assign m_awaddr = lookup.xaddr;
	assign m_arlen = len_q;
	assign m_awlen = len_q;
	assign m_arvalid = (state == ARB_RD_ISSUE);
	assign m_awvalid = (state == ARB_WR_ISSUE);
	assign s_arready = (state == ARB_RD_ISSUE) && m_arready;
	assign s_awready = (state == ARB_WR_ISSUE) && m_awready;
	assign m_wvalid = (state == ARB_WR_DATA) && s_wvalid;
	assign s_wready = (state == ARB_WR_DATA) && m_wready;

	assign wr_start = (state == ARB_WR_ISSUE) && m_awready;
	assign wr_beat = m_wvalid && m_wready;
	assign wr_done = wr_beat && m_wlast_seen;

	always_comb
	begin
		state_nx = state;
		case (state)
			ARB_IDLE:
				if (take_rd)
					state_nx = ARB_RD_ISSUE;
				else if (take_wr)
					state_nx = ARB_WR_ISSUE;
			ARB_RD_ISSUE:
				if (m_arready)
					state_nx = ARB_IDLE;
			ARB_WR_ISSUE:
				if (m_awready)
					state_nx = ARB_WR_DATA;
			ARB_WR_DATA:
				if (wr_done)
					state_nx = ARB_IDLE;
			default: state_nx = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			state <= ARB_IDLE;
		else
			state <= state_nx;
	end

	// Hit flag of the burst whose data is flowing
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			wr_hit <= 1'b0;
		else if (wr_start)
			wr_hit <= lookup.hit;
		else if (wr_done)
			wr_hit <= 1'b0;
	end

	// Masking follows the same window as the write address phase
	a_wr_hit_live: assert property (@(posedge clk) disable iff (!rstnn)
		(state == ARB_WR_DATA) |-> (wr_hit == lookup.hit));

	// Translated write address holds while the downstream stalls
	a_aw_stable: assert property (@(posedge clk) disable iff (!rstnn)
		m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr));

endmodule

//--- design/tcu_wstrb_mask.sv
`timescale 1ns/10ps

module tcu_wstrb_mask
(
	input  logic clk,
	input  logic rstnn,
	input  logic wr_start,
	input  logic wr_beat,
	input  logic wr_hit,
	input  tcu_pkg::addr_t start_addr,
	input  tcu_pkg::addr_t limit,
	input  tcu_pkg::strb_t s_wstrb,
	output tcu_pkg::strb_t m_wstrb
);
	import tcu_pkg::*;

	addr_t beat_addr;
	logic past_limit;

	// Original-space address of the beat on the W channel
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			beat_addr <= '0;
		else if (wr_start)
			beat_addr <= start_addr;
		else if (wr_beat)
			beat_addr <= beat_addr + addr_t'(TCU_BEAT_BYTES);
	end

	// ********************************************************
	// Strobe masking
	// A beat at or past the window end must not reach the target
	assign past_limit = (beat_addr >= limit);
	assign m_wstrb = (wr_hit && past_limit) ? '0 : s_wstrb;

	// The first beat of a burst always lies inside its window
	a_first_beat_kept: assert property (@(posedge clk) disable iff (!rstnn)
		wr_start |=> (m_wstrb == s_wstrb));

endmodule

//--- design/tcu_top.sv
`timescale 1ns/10ps

module tcu_top
(
	input  logic clk,
	input  logic rstnn,

	// Requester side
	input  tcu_pkg::addr_t s_awaddr,
	input  tcu_pkg::len_t s_awlen,
	input  logic s_awvalid,
	output logic s_awready,
	input  tcu_pkg::data_t s_wdata,
	input  tcu_pkg::strb_t s_wstrb,
	input  logic s_wlast,
	input  logic s_wvalid,
	output logic s_wready,
	output tcu_pkg::resp_t s_bresp,
	output logic s_bvalid,
	input  logic s_bready,
	input  tcu_pkg::addr_t s_araddr,
	input  tcu_pkg::len_t s_arlen,
	input  logic s_arvalid,
	output logic s_arready,
	output tcu_pkg::data_t s_rdata,
	output tcu_pkg::resp_t s_rresp,
	output logic s_rlast,
	output logic s_rvalid,
	input  logic s_rready,

	// Downstream side
	output tcu_pkg::addr_t m_awaddr,
	output tcu_pkg::len_t m_awlen,
	output logic m_awvalid,
	input  logic m_awready,
	output tcu_pkg::data_t m_wdata,
	output tcu_pkg::strb_t m_wstrb,
	output logic m_wlast,
	output logic m_wvalid,
	input  logic m_wready,
	input  tcu_pkg::resp_t m_bresp,
	input  logic m_bvalid,
	output logic m_bready,
	output tcu_pkg::addr_t m_araddr,
	output tcu_pkg::len_t m_arlen,
	output logic m_arvalid,
	input  logic m_arready,
	input  tcu_pkg::data_t m_rdata,
	input  tcu_pkg::resp_t m_rresp,
	input  logic m_rlast,
	input  logic m_rvalid,
	output logic m_rready,

	// Configuration
	input  tcu_pkg::addr_t paddr,
	input  logic pwrite,
	input  logic psel,
	input  logic penable,
	input  tcu_pkg::data_t pwdata,
	output tcu_pkg::data_t prdata,
	output logic pready,
	output logic pslverr
);

	logic wr_start;
	logic wr_beat;
	logic wr_hit;

	tcu_region_if region_bus ();
	tcu_lookup_if lookup_bus ();

	tcu_apb_regs u_apb_regs (
		.clk(clk), .rstnn(rstnn),
		.paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.region(region_bus.regs)
	);

	tcu_region_match u_region_match (
		.region(region_bus.match),
		.lookup(lookup_bus.server)
	);

	tcu_addr_arbiter u_addr_arbiter (
		.clk(clk), .rstnn(rstnn),
		.s_araddr(s_araddr), .s_arlen(s_arlen),
		.s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_awaddr(s_awaddr), .s_awlen(s_awlen),
		.s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wvalid(s_wvalid), .s_wready(s_wready),
		.m_araddr(m_araddr), .m_arlen(m_arlen),
		.m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_awaddr(m_awaddr), .m_awlen(m_awlen),
		.m_awvalid(m_awvalid), .m_awready(m_awready),
		.m_wvalid(m_wvalid), .m_wready(m_wready),
		.m_wlast_seen(s_wlast),
		.wr_start(wr_start), .wr_beat(wr_beat), .wr_hit(wr_hit),
		.lookup(lookup_bus.client)
	);

	// The lookup still holds the write address during the data phase
	tcu_wstrb_mask u_wstrb_mask (
		.clk(clk), .rstnn(rstnn),
		.wr_start(wr_start), .wr_beat(wr_beat), .wr_hit(wr_hit),
		.start_addr(lookup_bus.addr), .limit(lookup_bus.limit),
		.s_wstrb(s_wstrb), .m_wstrb(m_wstrb)
	);

	// ********************************************************
	// Pass-through paths
	assign m_wdata = s_wdata;
	assign m_wlast = s_wlast;

	assign s_bresp = m_bresp;
	assign s_bvalid = m_bvalid;
	assign m_bready = s_bready;

	assign s_rdata = m_rdata;
	assign s_rresp = m_rresp;
	assign s_rlast = m_rlast;
	assign s_rvalid = m_rvalid;
	assign m_rready = s_rready;

endmodule

//--- sim/tcu_tb.sv
`timescale 1ns/10ps

module tcu_tb;
	import tcu_pkg::*;

	localparam int CLK_PERIOD = 20;
	// Six test budgets of 300 cycles each
	localparam int WATCHDOG_NS = 6 * 300 * CLK_PERIOD;

	logic clk = 1'b0;
	logic rstnn;

	// Requester side driven by the tests
	addr_t s_awaddr;
	len_t s_awlen;
	logic s_awvalid;
	logic s_awready;
	data_t s_wdata;
	strb_t s_wstrb;
	logic s_wlast;
	logic s_wvalid;
	logic s_wready;
	resp_t s_bresp;
	logic s_bvalid;
	logic s_bready = 1'b0;
	addr_t s_araddr;
	len_t s_arlen;
	logic s_arvalid;
	logic s_arready;
	data_t s_rdata;
	resp_t s_rresp;
	logic s_rlast;
	logic s_rvalid;
	logic s_rready = 1'b0;

	// Downstream side driven by the port model
	addr_t m_awaddr;
	len_t m_awlen;
	logic m_awvalid;
	logic m_awready = 1'b0;
	data_t m_wdata;
	strb_t m_wstrb;
	logic m_wlast;
	logic m_wvalid;
	logic m_wready = 1'b0;
	resp_t m_bresp = '0;
	logic m_bvalid = 1'b0;
	logic m_bready;
	addr_t m_araddr;
	len_t m_arlen;
	logic m_arvalid;
	logic m_arready = 1'b0;
	data_t m_rdata = '0;
	resp_t m_rresp = '0;
	logic m_rlast = 1'b0;
	logic m_rvalid = 1'b0;
	logic m_rready;

	// APB configuration port
	addr_t paddr;
	logic pwrite;
	logic psel;
	logic penable;
	data_t pwdata;
	data_t prdata;
	logic pready;
	logic pslverr;

	int errors = 0;
	int tests_run = 0;
	int tests_ok = 0;
	logic rand_ready = 1'b0;
	logic [15:0] lfsr = 16'd58;

	// Transfer logs filled by the port model
	addr_t ar_addr_log[$];
	int ar_cyc_log[$];
	addr_t aw_addr_log[$];
	len_t aw_len_log[$];
	int aw_cyc_log[$];
	data_t w_data_log[$];
	strb_t w_strb_log[$];
	logic w_last_log[$];
	data_t r_data_log[$];
	resp_t r_resp_log[$];
	logic r_last_log[$];
	resp_t b_resp_log[$];
	resp_t b_sent_log[$];
	int ar0;
	int aw0;
	int w0;
	int r0;
	int b0;

	// Port model state
	addr_t rd_addr_q[$];
	int rd_len_q[$];
	logic r_busy;
	addr_t r_addr;
	int r_left;
	int r_beat;
	logic b_busy;
	int b_pend;
	int b_seq;
	int cyc;

	tcu_top u_tcu_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic rand_bit();
		lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		return lfsr[0];
	endfunction

	function automatic data_t rdata_pattern(input addr_t a, input int beat);
		return a ^ {8'(beat), 24'h5A3C00};
	endfunction

	function automatic data_t wdata_pattern(input addr_t a, input int beat);
		return ~a + data_t'(beat);
	endfunction

	function automatic strb_t beat_strb(input int beat);
		return strb_t'(15 >> (beat % 4));
	endfunction

	function automatic addr_t region_reg(input int idx, input logic [3:0] ofs);
		return addr_t'(REG_REGION_BASE) + addr_t'(16 * idx) + addr_t'(ofs);
	endfunction

	// ********************************************************
	// Downstream port model that also sinks B and R for the requester
	always @(posedge clk)
	begin
		if (!rstnn)
		begin
			m_arready <= 1'b0;
			m_awready <= 1'b0;
			m_wready <= 1'b0;
			s_bready <= 1'b0;
			s_rready <= 1'b0;
			m_rvalid <= 1'b0;
			m_rlast <= 1'b0;
			m_bvalid <= 1'b0;
			r_busy = 1'b0;
			b_busy = 1'b0;
			b_pend = 0;
			b_seq = 0;
			cyc = 0;
		end
		else
		begin
			cyc = cyc + 1;
			if (m_arvalid && m_arready)
			begin
				ar_addr_log.push_back(m_araddr);
				ar_cyc_log.push_back(cyc);
				rd_addr_q.push_back(m_araddr);
				rd_len_q.push_back(int'(m_arlen));
			end
			if (m_awvalid && m_awready)
			begin
				aw_addr_log.push_back(m_awaddr);
				aw_len_log.push_back(m_awlen);
				aw_cyc_log.push_back(cyc);
			end
			if (m_wvalid && m_wready)
			begin
				w_data_log.push_back(m_wdata);
				w_strb_log.push_back(m_wstrb);
				w_last_log.push_back(m_wlast);
				if (m_wlast)
					b_pend = b_pend + 1;
			end

			// R beats as seen by the requester
			if (s_rvalid && s_rready)
			begin
				r_data_log.push_back(s_rdata);
				r_resp_log.push_back(s_rresp);
				r_last_log.push_back(s_rlast);
			end
			if (m_rvalid && m_rready)
			begin
				if (r_left == 0)
					r_busy = 1'b0;
				else
				begin
					r_left = r_left - 1;
					r_beat = r_beat + 1;
				end
			end
			if (!r_busy && rd_addr_q.size() > 0)
			begin
				r_busy = 1'b1;
				r_addr = rd_addr_q.pop_front();
				r_left = rd_len_q.pop_front();
				r_beat = 0;
			end
			m_rvalid <= r_busy;
			m_rdata <= rdata_pattern(r_addr, r_beat);
			m_rresp <= resp_t'(r_beat);
			m_rlast <= r_busy && (r_left == 0);

			if (s_bvalid && s_bready)
			begin
				b_resp_log.push_back(s_bresp);
				b_sent_log.push_back(m_bresp);
			end
			if (m_bvalid && m_bready)
			begin
				b_busy = 1'b0;
				b_seq = b_seq + 1;
			end
			if (!b_busy && b_pend > 0)
			begin
				b_busy = 1'b1;
				b_pend = b_pend - 1;
			end
			m_bvalid <= b_busy;
			m_bresp <= resp_t'(b_seq + 1);

			if (rand_ready)
			begin
				m_arready <= rand_bit();
				m_awready <= rand_bit();
				m_wready <= rand_bit();
				s_bready <= rand_bit();
				s_rready <= rand_bit();
			end
			else
			begin
				m_arready <= 1'b1;
				m_awready <= 1'b1;
				m_wready <= 1'b1;
				s_bready <= 1'b1;
				s_rready <= 1'b1;
			end
		end
	end

	// ********************************************************
	// Compare tasks
	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_strb(input string what, input strb_t got, input strb_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_resp(input string what, input resp_t got, input resp_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic check_len(input string what, input len_t got, input len_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic complain(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors = errors + 1;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run = tests_run + 1;
		if (errors == errs_before)
		begin
			tests_ok = tests_ok + 1;
			$display("[%0t] %s: ok", $time, name);
		end
		else
			$display("[%0t] %s: %0d errors", $time, name, errors - errs_before);
	endtask

	// ********************************************************
	// APB access started right after a rising edge
	task automatic apb_access(input addr_t addr, input logic wr, input data_t wdata,
		output data_t rdata, output logic err);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		do
			@(posedge clk);
		while (!pready);
		rdata = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input addr_t addr, input data_t data);
		data_t rd;
		logic err;
		apb_access(addr, 1'b1, data, rd, err);
		if (err)
			complain($sformatf("pslverr on write to offset %h", addr));
	endtask

	task automatic apb_read(input addr_t addr, output data_t data, output logic err);
		apb_access(addr, 1'b0, '0, data, err);
	endtask

	task automatic expect_reg(input addr_t addr, input data_t exp);
		data_t rd;
		logic err;
		apb_read(addr, rd, err);
		if (err)
			complain($sformatf("pslverr on read of mapped offset %h", addr));
		check_data($sformatf("prdata @%h", addr), rd, exp);
	endtask

	task automatic expect_unmapped(input addr_t addr);
		data_t rd;
		logic err;
		apb_read(addr, rd, err);
		if (!err)
			complain($sformatf("no pslverr for unmapped offset %h", addr));
		check_data($sformatf("prdata @%h", addr), rd, '0);
	endtask

	task automatic config_region(input int idx, input addr_t base, input addr_t limit,
		input addr_t target);
		apb_write(region_reg(idx, REG_BASE_OFS), base);
		apb_write(region_reg(idx, REG_LIMIT_OFS), limit);
		apb_write(region_reg(idx, REG_TARGET_OFS), target);
	endtask

	// ********************************************************
	// Requester side bursts
	task automatic mark_logs();
		ar0 = ar_addr_log.size();
		aw0 = aw_addr_log.size();
		w0 = w_data_log.size();
		r0 = r_data_log.size();
		b0 = b_resp_log.size();
	endtask

	task automatic send_read(input addr_t addr, input len_t len);
		s_araddr <= addr;
		s_arlen <= len;
		s_arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!s_arready);
		s_arvalid <= 1'b0;
	endtask

	task automatic send_write(input addr_t addr, input len_t len);
		s_awaddr <= addr;
		s_awlen <= len;
		s_awvalid <= 1'b1;
		do
			@(posedge clk);
		while (!s_awready);
		s_awvalid <= 1'b0;
		for (int i = 0; i <= int'(len); i++)
		begin
			s_wdata <= wdata_pattern(addr, i);
			s_wstrb <= beat_strb(i);
			s_wlast <= (i == int'(len));
			s_wvalid <= 1'b1;
			do
				@(posedge clk);
			while (!s_wready);
		end
		s_wvalid <= 1'b0;
		s_wlast <= 1'b0;
	endtask

	task automatic check_read_logs(input addr_t exp_x, input int beats);
		if (ar_addr_log.size() != ar0 + 1)
			complain($sformatf("%0d read addresses downstream, expected one",
				ar_addr_log.size() - ar0));
		else
			check_addr("m_araddr", ar_addr_log[ar0], exp_x);
		if (r_data_log.size() != r0 + beats)
			complain($sformatf("requester got %0d read beats, expected %0d",
				r_data_log.size() - r0, beats));
		else
		begin
			for (int j = 0; j < beats; j++)
			begin
				check_data("s_rdata", r_data_log[r0 + j], rdata_pattern(exp_x, j));
				check_resp("s_rresp", r_resp_log[r0 + j], resp_t'(j));
				if (r_last_log[r0 + j] != (j == beats - 1))
					complain($sformatf("s_rlast wrong on read beat %0d", j));
			end
		end
	endtask

	// keep is the number of leading beats that stay inside the window
	task automatic check_write_logs(input addr_t addr, input addr_t exp_x, input int beats,
		input int keep);
		if (aw_addr_log.size() != aw0 + 1)
			complain($sformatf("%0d write addresses downstream, expected one",
				aw_addr_log.size() - aw0));
		else
		begin
			check_addr("m_awaddr", aw_addr_log[aw0], exp_x);
			check_len("m_awlen", aw_len_log[aw0], len_t'(beats - 1));
		end
		if (w_data_log.size() != w0 + beats)
			complain($sformatf("downstream got %0d write beats, expected %0d",
				w_data_log.size() - w0, beats));
		else
		begin
			for (int i = 0; i < beats; i++)
			begin
				check_data("m_wdata", w_data_log[w0 + i], wdata_pattern(addr, i));
				check_strb("m_wstrb", w_strb_log[w0 + i], (i < keep) ? beat_strb(i) : '0);
				if (w_last_log[w0 + i] != (i == beats - 1))
					complain($sformatf("m_wlast wrong on write beat %0d", i));
			end
		end
		if (b_resp_log.size() != b0 + 1)
			complain($sformatf("requester got %0d write responses, expected one",
				b_resp_log.size() - b0));
		else
			check_resp("s_bresp", b_resp_log[b0], b_sent_log[b0]);
	endtask

	task automatic run_read(input addr_t addr, input len_t len, input addr_t exp_x);
		mark_logs();
		send_read(addr, len);
		while (r_data_log.size() < r0 + int'(len) + 1)
			@(posedge clk);
		repeat (3) @(posedge clk);
		check_read_logs(exp_x, int'(len) + 1);
	endtask

	task automatic run_write(input addr_t addr, input len_t len, input addr_t exp_x,
		input int keep);
		mark_logs();
		send_write(addr, len);
		while (b_resp_log.size() < b0 + 1)
			@(posedge clk);
		repeat (3) @(posedge clk);
		check_write_logs(addr, exp_x, int'(len) + 1, keep);
	endtask

	// ********************************************************
	// Directed tests
	task automatic test_regs();
		int e0;
		e0 = errors;
		config_region(0, 32'h1000, 32'h1100, 32'h8000_0000);
		config_region(1, 32'h2000, 32'h2040, 32'h9000_0000);
		apb_write(addr_t'(REG_ENABLE), 32'h3);
		expect_reg(addr_t'(REG_ENABLE), 32'h3);
		expect_reg(region_reg(0, REG_BASE_OFS), 32'h1000);
		expect_reg(region_reg(0, REG_LIMIT_OFS), 32'h1100);
		expect_reg(region_reg(0, REG_TARGET_OFS), 32'h8000_0000);
		expect_reg(region_reg(1, REG_BASE_OFS), 32'h2000);
		expect_reg(region_reg(1, REG_LIMIT_OFS), 32'h2040);
		expect_reg(region_reg(1, REG_TARGET_OFS), 32'h9000_0000);
		expect_unmapped(32'h04);
		expect_unmapped(32'h1C);
		expect_unmapped(32'h50);
		expect_unmapped(32'h110);
		report_test("Register file", e0);
	endtask

	task automatic test_read_xlate();
		int e0;
		e0 = errors;
		// Region 2 overlaps the top of region 0 and region 3 stays disabled
		config_region(2, 32'h1080, 32'h1200, 32'hA000_0000);
		config_region(3, 32'h3000, 32'h3100, 32'hB000_0000);
		apb_write(addr_t'(REG_ENABLE), 32'h7);
		run_read(32'h1010, 8'd1, 32'h8000_0010);
		run_read(32'h2020, 8'd1, 32'h9000_0020);
		run_read(32'h0500, 8'd1, 32'h0000_0500);
		run_read(32'h3010, 8'd1, 32'h0000_3010);
		run_read(32'h10C0, 8'd1, 32'h8000_00C0);
		run_read(32'h1180, 8'd1, 32'hA000_0100);
		report_test("Read translation", e0);
	endtask

	task automatic test_wr_mask();
		int e0;
		e0 = errors;
		// Starts two beats below the region 0 limit so the last two fall outside
		run_write(32'h10F8, 8'd3, 32'h8000_00F8, 2);
		run_write(32'h0600, 8'd3, 32'h0000_0600, 4);
		report_test("Write burst masking", e0);
	endtask

	task automatic test_priority();
		int e0;
		e0 = errors;
		mark_logs();
		fork
			send_read(32'h1010, 8'd0);
			send_write(32'h2000, 8'd1);
		join
		while (r_data_log.size() < r0 + 1 || b_resp_log.size() < b0 + 1)
			@(posedge clk);
		repeat (3) @(posedge clk);
		check_read_logs(32'h8000_0010, 1);
		check_write_logs(32'h2000, 32'h9000_0000, 2, 2);
		if (ar_cyc_log.size() > ar0 && aw_cyc_log.size() > aw0)
		begin
			if (ar_cyc_log[ar0] >= aw_cyc_log[aw0])
				complain("write address left before the read address");
		end
		report_test("Read priority", e0);
	endtask

	task automatic test_bp_reads();
		int e0;
		e0 = errors;
		rand_ready <= 1'b1;
		run_read(32'h1000, 8'd7, 32'h8000_0000);
		run_read(32'h0400, 8'd3, 32'h0000_0400);
		run_read(32'h2008, 8'd5, 32'h9000_0008);
		report_test("Back-pressure reads", e0);
	endtask

	task automatic test_bp_writes();
		int e0;
		e0 = errors;
		run_write(32'h2038, 8'd3, 32'h9000_0038, 2);
		run_write(32'h0800, 8'd5, 32'h0000_0800, 6);
		run_write(32'h1184, 8'd2, 32'hA000_0104, 3);
		rand_ready <= 1'b0;
		report_test("Back-pressure writes", e0);
	endtask

	initial
	begin
		rstnn <= 1'b0;
		s_awaddr <= '0;
		s_awlen <= '0;
		s_awvalid <= 1'b0;
		s_wdata <= '0;
		s_wstrb <= '0;
		s_wlast <= 1'b0;
		s_wvalid <= 1'b0;
		s_araddr <= '0;
		s_arlen <= '0;
		s_arvalid <= 1'b0;
		paddr <= '0;
		pwrite <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwdata <= '0;
		repeat (5) @(posedge clk);
		rstnn <= 1'b1;
		@(posedge clk);
		test_regs();
		test_read_xlate();
		test_wr_mask();
		test_priority();
		test_bp_reads();
		test_bp_writes();
		$display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- tcu.f
design/tcu_pkg.sv
design/tcu_if.sv
design/tcu_apb_regs.sv
design/tcu_region_match.sv
design/tcu_addr_arbiter.sv
design/tcu_wstrb_mask.sv
design/tcu_top.sv
sim/tcu_tb.sv

//--- Makefile
TOP = tcu_tb

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tcu.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
